// File: hw/csr_pkg.sv
// csr addresses, uart status bits, op and target enums, shared structs for the csr unit
package csr_pkg;

  // csr addresses
  localparam logic [11:0] addr_mcycle    = 12'hB00;
  localparam logic [11:0] addr_minstret  = 12'hB02;
  localparam logic [11:0] addr_mcycleh   = 12'hB80;
  localparam logic [11:0] addr_minstreth = 12'hB82;
  localparam logic [11:0] addr_muartstat = 12'hFC0;
  localparam logic [11:0] addr_muartrx   = 12'hFC1;
  localparam logic [11:0] addr_muarttx   = 12'h7C0;
  localparam logic [11:0] addr_bfs_base  = 12'h7D0;
  localparam logic [11:0] addr_ml2stat   = 12'h7E0;

  // uart status bits
  localparam logic [31:0] uartstat_rxempty = 32'h0000_0001;
  localparam logic [31:0] uartstat_txempty = 32'h0000_0004;

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_set   = 2'd2,
    op_clear = 2'd3
  } csr_op_e;

  typedef enum logic [3:0] {
    tgt_mcycle,
    tgt_mcycleh,
    tgt_minstret,
    tgt_minstreth,
    tgt_uartstat,
    tgt_uartrx,
    tgt_uarttx,
    tgt_bfs,
    tgt_l2stat,
    tgt_none
  } csr_target_e;

  // request from rename
  typedef struct packed {
    logic        write;
    csr_op_e     op;
    logic [6:0]  robid;
    logic [5:0]  rd;
    logic [31:0] op1;
    logic [11:0] imm;
  } csr_req_t;

  typedef struct packed {
    logic        valid;
    csr_op_e     op;
    logic [6:0]  robid;
    logic [5:0]  rd;
    logic [31:0] op1;
    logic [11:0] addr;
    csr_target_e target;
    logic        read_only;
  } csr_cmd_t;

  typedef struct packed {
    logic        wen;
    logic [31:0] wdata;
  } csr_wr_t;

  typedef struct packed {
    logic [31:0] mcycle;
    logic [31:0] mcycleh;
    logic [31:0] minstret;
    logic [31:0] minstreth;
  } csr_counters_t;

  // accelerator window
  typedef struct packed {
    logic        valid;
    logic [3:0]  addr;
    logic        wen;
    logic [31:0] wdata;
  } bfs_req_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] rdata;
  } bfs_rsp_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
    logic        busy;
    logic        stall;
  } ext_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [6:0]  robid;
    logic [5:0]  rd;
    logic [31:0] result;
  } csr_wb_t;

endpackage

// File: hw/csr_decode.sv
// csr command register and address decode into a target
`timescale 1ns/1ps

module csr_decode (
  input  logic              clk,
  input  logic              rst,
  input  csr_pkg::csr_req_t req,
  input  logic              stall,
  output csr_pkg::csr_cmd_t cmd
);

  import csr_pkg::*;

  csr_target_e target_d;
  logic        read_only_d;

  // decode straight from the immediate so target is ready with the command
  always_comb begin
    target_d = tgt_none;
    if (req.imm[11:4] == addr_bfs_base[11:4]) begin
      target_d = tgt_bfs;
    end else begin
      case (req.imm)
        addr_mcycle:    target_d = tgt_mcycle;
        addr_mcycleh:   target_d = tgt_mcycleh;
        addr_minstret:  target_d = tgt_minstret;
        addr_minstreth: target_d = tgt_minstreth;
        addr_muartstat: target_d = tgt_uartstat;
        addr_muartrx:   target_d = tgt_uartrx;
        addr_muarttx:   target_d = tgt_uarttx;
        addr_ml2stat:   target_d = tgt_l2stat;
        default:        target_d = tgt_none;
      endcase
    end
  end

  // top two address bits set marks a read-only csr
  assign read_only_d = &req.imm[11:10];

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd.valid <= 1'b0;
    end else if (!stall) begin
      cmd.valid <= req.write;
    end
  end

  // payload held while stalled
  always_ff @(posedge clk) begin
    if (!stall && req.write) begin
      cmd.op        <= req.op;
      cmd.robid     <= req.robid;
      cmd.rd        <= req.rd;
      cmd.op1       <= req.op1;
      cmd.addr      <= req.imm;
      cmd.target    <= target_d;
      cmd.read_only <= read_only_d;
    end
  end

endmodule

// File: hw/csr_counters.sv
// 64-bit cycle and retired instruction counters with csr write override
`timescale 1ns/1ps

module csr_counters (
  input  logic                   clk,
  input  logic                   rst,
  input  csr_pkg::csr_cmd_t      cmd,
  input  csr_pkg::csr_wr_t       wr,
  input  logic                   rob_ret_valid,
  output csr_pkg::csr_counters_t counters
);

  import csr_pkg::*;

  logic [63:0] cycle_q;
  logic [63:0] instret_q;
  logic [63:0] cycle_d;
  logic [63:0] instret_d;

  // explicit write replaces one half after the passive increment
  always_comb begin
    cycle_d   = cycle_q + 64'd1;
    instret_d = instret_q + {63'd0, rob_ret_valid};
    if (wr.wen) begin
      case (cmd.target)
        tgt_mcycle:    cycle_d[31:0]    = wr.wdata;
        tgt_mcycleh:   cycle_d[63:32]   = wr.wdata;
        tgt_minstret:  instret_d[31:0]  = wr.wdata;
        tgt_minstreth: instret_d[63:32] = wr.wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_q   <= 64'd0;
      instret_q <= 64'd0;
    end else begin
      cycle_q   <= cycle_d;
      instret_q <= instret_d;
    end
  end

  assign counters.mcycle    = cycle_q[31:0];
  assign counters.mcycleh   = cycle_q[63:32];
  assign counters.minstret  = instret_q[31:0];
  assign counters.minstreth = instret_q[63:32];

endmodule

// File: hw/csr_ext_port.sv
// external csr access: accelerator window, uart registers and l2 status
`timescale 1ns/1ps

module csr_ext_port (
  input  logic              clk,
  input  logic              rst,
  input  csr_pkg::csr_cmd_t cmd,
  input  csr_pkg::csr_wr_t  wr,
  input  logic              l2_req,
  output csr_pkg::bfs_req_t bfs_req,
  input  csr_pkg::bfs_rsp_t bfs_rsp,
  output csr_pkg::ext_rsp_t ext,
  output logic              uart_tx_valid,
  output logic [7:0]        uart_tx_data
);

  import csr_pkg::*;

  logic busy;
  logic bfs_sel;
  logic bfs_rmw;
  logic l2_wr;
  logic l2_hold;

  assign bfs_sel = cmd.valid && (cmd.target == tgt_bfs);
  // set and clear are not supported on the window
  assign bfs_rmw = (cmd.op == op_set) || (cmd.op == op_clear);

  assign bfs_req.valid = bfs_sel && !bfs_rmw && !busy;
  assign bfs_req.addr  = cmd.addr[3:0];
  assign bfs_req.wen   = wr.wen;
  assign bfs_req.wdata = cmd.op1;

  // second cycle of a window access
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else begin
      busy <= bfs_req.valid;
    end
  end

  assign l2_wr = wr.wen && (cmd.target == tgt_l2stat);

  always_ff @(posedge clk) begin
    if (rst || !l2_req) begin
      l2_hold <= 1'b0;
    end else if (l2_wr) begin
      l2_hold <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uart_tx_valid <= 1'b0;
    end else begin
      uart_tx_valid <= wr.wen && (cmd.target == tgt_uarttx);
    end
  end

  always_ff @(posedge clk) begin
    if (wr.wen && (cmd.target == tgt_uarttx)) begin
      uart_tx_data <= wr.wdata[7:0];
    end
  end

  always_comb begin
    case (cmd.target)
      tgt_uartstat: ext.rdata = uartstat_txempty | uartstat_rxempty;
      tgt_uartrx:   ext.rdata = 32'd0;
      tgt_uarttx:   ext.rdata = {24'd0, uart_tx_data};
      tgt_bfs:      ext.rdata = bfs_rsp.rdata;
      tgt_l2stat:   ext.rdata = {31'd0, l2_req};
      default:      ext.rdata = 32'd0;
    endcase
  end

  // missing response counts as an error
  assign ext.error = (busy && (!bfs_rsp.valid || bfs_rsp.error)) || (bfs_sel && bfs_rmw);
  assign ext.busy  = busy;
  assign ext.stall = bfs_req.valid || (l2_wr && l2_req) || (l2_hold && l2_req);

endmodule

// File: hw/csr_combine.sv
// csr read mux, read-modify-write data, error, stall and writeback
`timescale 1ns/1ps

module csr_combine (
  input  csr_pkg::csr_cmd_t      cmd,
  input  csr_pkg::csr_counters_t counters,
  input  csr_pkg::ext_rsp_t      ext,
  output csr_pkg::csr_wr_t       wr,
  output logic                   stall,
  output csr_pkg::csr_wb_t       wb
);

  import csr_pkg::*;

  logic [31:0] rdata;
  logic        is_write;
  logic        known;
  logic        ro_error;

  always_comb begin
    case (cmd.target)
      tgt_mcycle:    rdata = counters.mcycle;
      tgt_mcycleh:   rdata = counters.mcycleh;
      tgt_minstret:  rdata = counters.minstret;
      tgt_minstreth: rdata = counters.minstreth;
      default:       rdata = ext.rdata;
    endcase
  end

  always_comb begin
    case (cmd.op)
      op_write: wr.wdata = cmd.op1;
      op_set:   wr.wdata = rdata | cmd.op1;
      op_clear: wr.wdata = rdata & ~cmd.op1;
      default:  wr.wdata = 32'd0;
    endcase
  end

  assign is_write = cmd.op != op_read;
  assign known    = cmd.target != tgt_none;
  assign ro_error = is_write && cmd.read_only;

  assign wr.wen = cmd.valid && is_write && known && !cmd.read_only;

  assign stall = ext.stall;

  // result is always the value before the write
  assign wb.valid  = cmd.valid;
  assign wb.error  = cmd.valid && (!known || ro_error || ext.error);
  assign wb.robid  = cmd.robid;
  assign wb.rd     = cmd.rd;
  assign wb.result = rdata;

endmodule

// File: hw/csr_unit.sv
// csr unit top: decode, counters, external port and combine
`timescale 1ns/1ps

module csr_unit (
  input  logic              clk,
  input  logic              rst,
  input  csr_pkg::csr_req_t req,
  output logic              stall,
  output csr_pkg::csr_wb_t  wb,
  input  logic              rob_ret_valid,
  input  logic              l2_req,
  output csr_pkg::bfs_req_t bfs_req,
  input  csr_pkg::bfs_rsp_t bfs_rsp,
  output logic              uart_tx_valid,
  output logic [7:0]        uart_tx_data
);

  import csr_pkg::*;

  csr_cmd_t      cmd;
  csr_counters_t counters;
  ext_rsp_t      ext;
  csr_wr_t       wr;

  csr_decode decode_i (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .stall (stall),
    .cmd   (cmd)
  );

  csr_counters counters_i (
    .clk           (clk),
    .rst           (rst),
    .cmd           (cmd),
    .wr            (wr),
    .rob_ret_valid (rob_ret_valid),
    .counters      (counters)
  );

  csr_ext_port ext_port_i (
    .clk           (clk),
    .rst           (rst),
    .cmd           (cmd),
    .wr            (wr),
    .l2_req        (l2_req),
    .bfs_req       (bfs_req),
    .bfs_rsp       (bfs_rsp),
    .ext           (ext),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data)
  );

  csr_combine combine_i (
    .cmd      (cmd),
    .counters (counters),
    .ext      (ext),
    .wr       (wr),
    .stall    (stall),
    .wb       (wb)
  );

endmodule

// File: sim/csr_unit_checker.sv
// protocol assertions for the csr unit, bound into csr_unit
`timescale 1ns/1ps

module csr_unit_checker (
  input logic              clk,
  input logic              rst,
  input csr_pkg::csr_req_t req,
  input logic              stall,
  input csr_pkg::csr_wb_t  wb,
  input csr_pkg::bfs_req_t bfs_req
);

  import csr_pkg::*;

  // one pulse per window access
  bfs_single_pulse: assert property (
    @(posedge clk) disable iff (rst) bfs_req.valid |=> !bfs_req.valid
  ) else $error("accelerator request held for two cycles");

  // an accepted request shows up on wb in the next cycle
  wb_after_accept: assert property (
    @(posedge clk) disable iff (rst) (req.write && !stall) |=> wb.valid
  ) else $error("no writeback after an accepted request");

  // response cycle never stalls
  no_stall_after_bfs: assert property (
    @(posedge clk) disable iff (rst) bfs_req.valid |=> !stall
  ) else $error("stall high in the accelerator response cycle");

endmodule

bind csr_unit csr_unit_checker checker_i (
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .stall   (stall),
  .wb      (wb),
  .bfs_req (bfs_req)
);

// File: sim/csr_unit_tb.sv
// csr_unit testbench with clock, reset, accelerator model, directed tests and watchdog
`timescale 1ns/1ps

module csr_unit_tb;

  import csr_pkg::*;

  // longest test sequence stays well under this
  localparam int watchdog_cycles = 2000;
  localparam int wait_limit      = 50;

  logic       clk;
  logic       rst;
  csr_req_t   req;
  logic       stall;
  csr_wb_t    wb;
  logic       rob_ret_valid;
  logic       l2_req;
  bfs_req_t   bfs_req;
  bfs_rsp_t   bfs_rsp;
  logic       uart_tx_valid;
  logic [7:0] uart_tx_data;

  integer      seed;
  int          errors;
  int          checks;
  int          cycle_cnt;
  int          bfs_pulses;
  int          tx_pulses;
  logic [7:0]  tx_byte;
  logic [6:0]  robid_next;
  logic [31:0] last_result;
  logic        last_err;
  int          last_stalls;
  int          last_done;
  logic [31:0] bfs_mem [16];

  csr_unit dut_i (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .stall         (stall),
    .wb            (wb),
    .rob_ret_valid (rob_ret_valid),
    .l2_req        (l2_req),
    .bfs_req       (bfs_req),
    .bfs_rsp       (bfs_rsp),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // accelerator model answering in the cycle after a request
  initial begin
    bfs_req_t seen;
    for (int i = 0; i < 16; i++) begin
      bfs_mem[i] = 32'hC0DE_0000 | (32'(i) * 32'h0000_1111);
    end
    forever begin
      @(negedge clk);
      seen = bfs_req;
      if (seen.valid === 1'b1) begin
        bfs_pulses++;
      end
      @(posedge clk);
      #10;
      bfs_rsp.valid = seen.valid === 1'b1;
      bfs_rsp.error = (seen.valid === 1'b1) && (seen.addr == 4'hF);
      bfs_rsp.rdata = (seen.valid === 1'b1) ? bfs_mem[seen.addr] : 32'd0;
      if (seen.valid === 1'b1 && seen.wen) begin
        bfs_mem[seen.addr] = seen.wdata;
      end
    end
  end

  // uart transmit monitor
  always @(negedge clk) begin
    if (uart_tx_valid === 1'b1) begin
      tx_pulses <= tx_pulses + 1;
      tx_byte   <= uart_tx_data;
    end
  end

  initial begin
    #(watchdog_cycles * 100);
    $display("watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic issue(input csr_op_e op, input logic [11:0] addr, input logic [31:0] op1);
    int         waited;
    logic [6:0] robid;
    logic [5:0] rd;
    @(posedge clk);
    #10;
    robid      = robid_next;
    robid_next = robid_next + 7'd1;
    rd         = robid[5:0] ^ 6'h2A;
    req.write  = 1'b1;
    req.op     = op;
    req.robid  = robid;
    req.rd     = rd;
    req.op1    = op1;
    req.imm    = addr;
    waited     = 0;
    @(negedge clk);
    while (stall && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    #10;
    req.write   = 1'b0;
    last_stalls = 0;
    waited      = 0;
    @(negedge clk);
    while (!(wb.valid && !stall) && waited < wait_limit) begin
      if (wb.valid && stall) begin
        last_stalls++;
      end
      @(negedge clk);
      waited++;
    end
    checks++;
    assert (waited < wait_limit) else begin
      $display("writeback never arrived for address %h", addr);
      errors++;
    end
    last_result = wb.result;
    last_err    = wb.error;
    last_done   = cycle_cnt;
    check_value("wb.robid", 32'(wb.robid), 32'(robid));
    check_value("wb.rd", 32'(wb.rd), 32'(rd));
  endtask

  task automatic cycle_counter_test();
    logic [31:0] v;
    logic [31:0] k;
    int          wr_done;
    v = $random(seed);
    v = v & 32'h7FFF_FFFF;
    issue(op_write, addr_mcycle, v);
    wr_done = last_done;
    repeat (3) @(posedge clk);
    issue(op_read, addr_mcycle, 32'd0);
    k = 32'(last_done - (wr_done + 1));
    check_value("mcycle", last_result, v + k);
    issue(op_read, addr_mcycleh, 32'd0);
    check_value("mcycleh", last_result, 32'd0);
  endtask

  task automatic retire_counter_test();
    logic [31:0] tmp;
    int          n;
    issue(op_write, addr_minstret, 32'd0);
    tmp = $random(seed);
    n   = int'(tmp[3:0]) + 1;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #10 rob_ret_valid = 1'b1;
      @(posedge clk);
      #10 rob_ret_valid = 1'b0;
    end
    issue(op_read, addr_minstret, 32'd0);
    check_value("minstret", last_result, 32'(n));
  endtask

  task automatic read_modify_write_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    issue(op_write, addr_mcycleh, a);
    check_value("wb.result write", last_result, 32'd0);
    issue(op_set, addr_mcycleh, b);
    check_value("wb.result set", last_result, a);
    issue(op_clear, addr_mcycleh, c);
    check_value("wb.result clear", last_result, a | b);
    issue(op_read, addr_mcycleh, 32'd0);
    check_value("mcycleh", last_result, (a | b) & ~c);
  endtask

  task automatic error_flag_test();
    int pulses;
    issue(op_read, 12'h123, 32'd0);
    check_value("wb.error unknown", 32'(last_err), 32'd1);
    issue(op_write, addr_muartstat, 32'hFFFF_FFFF);
    check_value("wb.error ro write", 32'(last_err), 32'd1);
    pulses = bfs_pulses;
    issue(op_set, addr_bfs_base + 12'd5, 32'h1);
    check_value("wb.error window set", 32'(last_err), 32'd1);
    @(negedge clk);
    check_value("bfs_req pulses", 32'(bfs_pulses), 32'(pulses));
    issue(op_read, addr_muartstat, 32'd0);
    check_value("wb.error uartstat", 32'(last_err), 32'd0);
    check_value("uartstat", last_result, uartstat_txempty | uartstat_rxempty);
  endtask

  task automatic accelerator_test();
    logic [31:0] d;
    d = $random(seed);
    issue(op_write, addr_bfs_base + 12'd3, d);
    check_value("stall cycles write", 32'(last_stalls), 32'd1);
    check_value("wb.error bfs write", 32'(last_err), 32'd0);
    issue(op_read, addr_bfs_base + 12'd3, 32'd0);
    check_value("stall cycles read", 32'(last_stalls), 32'd1);
    check_value("bfs rdata", last_result, d);
    issue(op_read, addr_bfs_base + 12'hF, 32'd0);
    check_value("wb.error bfs 15", 32'(last_err), 32'd1);
  endtask

  task automatic uart_l2_test();
    int pulses;
    int drop_cycle;
    pulses = tx_pulses;
    issue(op_write, addr_muarttx, 32'h0000_01A5);
    repeat (2) @(negedge clk);
    check_value("uart_tx pulses", 32'(tx_pulses), 32'(pulses + 1));
    check_value("uart_tx_data", 32'(tx_byte), 32'h0000_00A5);
    @(posedge clk);
    #10 l2_req = 1'b1;
    issue(op_read, addr_ml2stat, 32'd0);
    check_value("l2stat high", last_result, 32'd1);
    @(posedge clk);
    #10 l2_req = 1'b0;
    issue(op_read, addr_ml2stat, 32'd0);
    check_value("l2stat low", last_result, 32'd0);
    @(posedge clk);
    #10 l2_req = 1'b1;
    fork
      issue(op_write, addr_ml2stat, 32'd1);
      begin
        repeat (5) @(posedge clk);
        #10 l2_req = 1'b0;
        drop_cycle = cycle_cnt;
      end
    join
    checks++;
    assert (last_stalls >= 2) else begin
      $display("l2stat write did not stall while l2_req was high");
      errors++;
    end
    check_value("l2 done cycle", 32'(last_done), 32'(drop_cycle));
  endtask

  initial begin
    seed          = 32'h3864;
    errors        = 0;
    checks        = 0;
    cycle_cnt     = 0;
    bfs_pulses    = 0;
    tx_pulses     = 0;
    tx_byte       = 8'd0;
    robid_next    = 7'd0;
    rst           = 1'b1;
    req           = '0;
    rob_ret_valid = 1'b0;
    l2_req        = 1'b0;
    bfs_rsp       = '0;
    repeat (2) @(posedge clk);
    #10 rst = 1'b0;

    cycle_counter_test();
    retire_counter_test();
    read_modify_write_test();
    error_flag_test();
    accelerator_test();
    uart_l2_test();

    repeat (2) @(posedge clk);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: csr_unit.f
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_counters.sv
hw/csr_ext_port.sv
hw/csr_combine.sv
hw/csr_unit.sv
sim/csr_unit_checker.sv
sim/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the csr unit simulation with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f csr_unit.f \
  --top-module csr_unit_tb \
  -o csr_unit_sim

./obj_dir/csr_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  echo "simulation ok"
  exit 0
else
  echo "simulation reported failure"
  exit 1
fi
